// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= src_streamer_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
verilog/src_cfg_pkg.sv
verilog/mem_if_pkg.sv
verilog/src_addrgen.sv
verilog/src_req_issue.sv
verilog/src_realign.sv
verilog/src_ctrl.sv
verilog/src_streamer.sv
dv/src_mem_model.sv
dv/src_streamer_tb.sv

// ==== dv/src_mem_model.sv ====
// in-order load memory where byte b holds (b*7+3) mod 256; keeps at most OFS_DEPTH loads outstanding
`timescale 1ns/1ps

module src_mem_model (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,   // drops every outstanding load
  input  mem_if_pkg::mem_req_t mem_req_i,
  output logic                 gnt_o,
  input  logic                 gnt_rnd_i, // grant allowed this cycle
  input  logic [1:0]           lat_rnd_i, // extra response delay, 0..3
  output mem_if_pkg::mem_rsp_t rsp_o,
  input  logic                 r_ready_i
);
  import src_cfg_pkg::*;
  import mem_if_pkg::*;

  mem_word_t data_q[$]; // granted loads, oldest first
  longint    due_q[$];  // first cycle each load may show up
  longint    cyc;
  logic      room_q;    // below the outstanding limit

  function automatic mem_word_t word_at(input addr_t a);
    mem_word_t w;
    for (int i = 0; i < MEM_DW / 8; i++) begin
      w[8*i +: 8] = 8'((a + addr_t'(i)) * 7 + 3); // little endian bytes
    end
    return w;
  endfunction

  assign gnt_o = mem_req_i.req & gnt_rnd_i & room_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q.delete();
      due_q.delete();
      cyc = 0;
      rsp_o  <= '0;
      room_q <= 1'b1;
    end else begin
      cyc = cyc + 1;
      if (clear_i) begin
        data_q.delete(); // pending answers are lost
        due_q.delete();
      end else begin
        if (rsp_o.r_valid && r_ready_i) begin
          void'(data_q.pop_front()); // head taken by the DUT
          void'(due_q.pop_front());
        end
        if (gnt_o) begin
          data_q.push_back(word_at(mem_req_i.addr));
          due_q.push_back(cyc + longint'(lat_rnd_i) + 1); // 1 to 4 cycles
        end
      end
      if (data_q.size() > 0 && due_q[0] <= cyc) begin
        rsp_o.r_valid <= 1'b1; // held until r_ready
        rsp_o.r_data  <= data_q[0];
      end else begin
        rsp_o.r_valid <= 1'b0;
      end
      room_q <= data_q.size() < OFS_DEPTH;
    end
  end

endmodule

// ==== dv/src_streamer_tb.sv ====
// directed tests of the streamer; one LFSR feeds grants, response delay and stream back-pressure
`timescale 1ns/1ps

module src_streamer_tb;
  import src_cfg_pkg::*;
  import mem_if_pkg::*;

  localparam int unsigned TEST_BEATS = 16 + 24 + 12 + 32 + 32; // beats over all tests
  localparam int unsigned MAX_CYCLES = TEST_BEATS * 20 + 200;
  localparam src_flags_t  IDLE_FLAGS = '{ready_start: 1'b1, done: 1'b0};

  logic         clk_i;
  logic         rst_ni;
  logic         clear;
  src_ctrl_t    ctrl;
  src_flags_t   flags;
  mem_req_t     mem_req;
  logic         mem_gnt;
  mem_rsp_t     mem_rsp;
  logic         mem_r_ready;
  stream_beat_t out;
  logic         out_ready;
  logic         gnt_rnd;
  logic [1:0]   lat_rnd;
  logic         bp_en;     // random out_ready when set
  logic [31:0]  lfsr_q;
  stream_word_t got_q[$];  // beats taken from the stream
  int unsigned  done_cnt;
  int unsigned  err_cnt;
  int unsigned  check_cnt;
  int unsigned  cyc_cnt;

  src_streamer src_streamer_inst (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear       ),
    .ctrl_i        ( ctrl        ),
    .flags_o       ( flags       ),
    .mem_req_o     ( mem_req     ),
    .mem_gnt_i     ( mem_gnt     ),
    .mem_rsp_i     ( mem_rsp     ),
    .mem_r_ready_o ( mem_r_ready ),
    .out_o         ( out         ),
    .out_ready_i   ( out_ready   )
  );

  src_mem_model mem_inst (
    .clk_i     ( clk_i       ),
    .rst_ni    ( rst_ni      ),
    .clear_i   ( clear       ),
    .mem_req_i ( mem_req     ),
    .gnt_o     ( mem_gnt     ),
    .gnt_rnd_i ( gnt_rnd     ),
    .lat_rnd_i ( lat_rnd     ),
    .rsp_o     ( mem_rsp     ),
    .r_ready_i ( mem_r_ready )
  );

  always #5 clk_i = ~clk_i;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic rand_bit();
    lfsr_q = lfsr_step(lfsr_q);
    return lfsr_q[0];
  endfunction

  function automatic stream_word_t pattern_word(input addr_t a);
    stream_word_t w;
    for (int i = 0; i < STREAM_DW / 8; i++) begin
      w[8*i +: 8] = 8'((a + addr_t'(i)) * 7 + 3); // byte b holds b*7+3
    end
    return w;
  endfunction

  // random inputs change on the falling edge only
  always @(negedge clk_i) begin
    gnt_rnd = rand_bit();
    lat_rnd = {rand_bit(), rand_bit()};
    if (bp_en) out_ready = rand_bit();
    else       out_ready = 1'b1;
  end

  always @(posedge clk_i) begin
    if (rst_ni && out.valid && out_ready) got_q.push_back(out.data);
    if (rst_ni && flags.done) done_cnt++;
  end

  always @(posedge clk_i) begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYCLES) begin
      $display("timeout: transfers did not finish within %0d cycles", MAX_CYCLES);
      $display("checks %0d, errors %0d", check_cnt, err_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic compare_word(input stream_word_t got, input stream_word_t exp,
                              input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_flags(input src_flags_t got, input src_flags_t exp,
                               input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_len(input len_t got, input len_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic start_transfer(input addr_t base, input len_t ilen, input stride_t istr,
                                input len_t ocnt, input stride_t ostr);
    @(negedge clk_i);
    got_q.delete();
    done_cnt = 0;
    ctrl.base         = base;
    ctrl.inner_len    = ilen;
    ctrl.inner_stride = istr;
    ctrl.outer_cnt    = ocnt;
    ctrl.outer_stride = ostr;
    ctrl.req_start    = 1'b1;
    @(negedge clk_i);
    ctrl.req_start = 1'b0; // single cycle pulse
  endtask

  // nested walk with rows outside
  task automatic expect_beats(input addr_t base, input len_t ilen, input stride_t istr,
                              input len_t ocnt, input stride_t ostr);
    addr_t row;
    addr_t a;
    int    idx;
    row = base;
    idx = 0;
    for (int o = 0; o < int'(ocnt); o++) begin
      a = row;
      for (int i = 0; i < int'(ilen); i++) begin
        if (idx < got_q.size()) begin
          compare_word(got_q[idx], pattern_word(a), $sformatf("beat %0d", idx));
        end
        a = a + addr_t'(istr);
        idx++;
      end
      row = row + addr_t'(ostr);
    end
    compare_len(len_t'(got_q.size()), len_t'(idx), "beat count"); // length of the walk
  endtask

  task automatic run_transfer(input addr_t base, input len_t ilen, input stride_t istr,
                              input len_t ocnt, input stride_t ostr);
    start_transfer(base, ilen, istr, ocnt, ostr);
    while (done_cnt == 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i); // a second pulse would show here
    compare_len(len_t'(done_cnt), len_t'(1), "done pulses");
    compare_flags(flags, IDLE_FLAGS, "flags after done");
    expect_beats(base, ilen, istr, ocnt, ostr);
  endtask

  task automatic reset_values();
    compare_bit(mem_req.req, 1'b0, "req after reset");
    compare_bit(out.valid, 1'b0, "valid after reset");
    compare_flags(flags, IDLE_FLAGS, "flags after reset");
  endtask

  task automatic aligned_transfer();
    run_transfer(32'h100, 16, 4, 1, 0);
  endtask

  task automatic misaligned_bases();
    run_transfer(32'h301, 8, 4, 1, 0);
    run_transfer(32'h402, 8, 4, 1, 0);
    run_transfer(32'h503, 8, 4, 1, 0);
  endtask

  task automatic two_dim_pattern();
    run_transfer(32'h601, 4, 8, 3, 100); // 12 beats
  endtask

  task automatic random_backpressure();
    bp_en <= 1'b1; // takes effect from the next falling edge
    run_transfer(32'h2003, 8, 4, 4, 64);
    bp_en <= 1'b0;
  endtask

  task automatic clear_mid_transfer();
    start_transfer(32'h100, 16, 4, 1, 0);
    while (got_q.size() < 4) @(negedge clk_i);
    clear = 1'b1;
    @(negedge clk_i);
    clear = 1'b0;
    compare_bit(out.valid, 1'b0, "valid after clear");
    compare_bit(mem_req.req, 1'b0, "req after clear");
    compare_flags(flags, IDLE_FLAGS, "flags after clear");
    aligned_transfer(); // restart must behave like a fresh one
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    clear     = 1'b0;
    ctrl      = '0;
    out_ready = 1'b1;
    gnt_rnd   = 1'b0;
    lat_rnd   = 2'b00;
    bp_en     = 1'b0;
    lfsr_q    = 32'h6793;
    done_cnt  = 0;
    err_cnt   = 0;
    check_cnt = 0;
    cyc_cnt   = 0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    reset_values();
    aligned_transfer();
    misaligned_bases();
    two_dim_pattern();
    random_backpressure();
    clear_mid_transfer();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/mem_if_pkg.sv ====
// memory word is one stream word plus 32 bits so any byte offset 0..3 fits
package mem_if_pkg;

  localparam int unsigned STREAM_DW = 32;
  localparam int unsigned MEM_DW    = STREAM_DW + 32; // slack for misalignment

  typedef logic [STREAM_DW-1:0] stream_word_t;
  typedef logic [MEM_DW-1:0]    mem_word_t;    // little endian bytes
  typedef logic [1:0]           ofs_t;         // byte offset inside a stream word

  typedef struct packed {
    logic               req;  // held until gnt
    src_cfg_pkg::addr_t addr; // low two bits always zero
  } mem_req_t;

  typedef struct packed {
    logic      r_valid; // held by memory until r_ready
    mem_word_t r_data;
  } mem_rsp_t;

  typedef struct packed {
    logic         valid;
    stream_word_t data;
  } stream_beat_t;

endpackage

// ==== verilog/src_addrgen.sv ====
// config is sampled on the rising edge of run_i; zero lengths are not supported
`timescale 1ns/1ps

module src_addrgen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  run_i,
  input  src_cfg_pkg::src_ctrl_t cfg_i,
  output src_cfg_pkg::addr_t    addr_o,
  output logic                  addr_valid_o,
  input  logic                  addr_ready_i,
  output logic                  done_o
);
  import src_cfg_pkg::*;

  src_ctrl_t cfg_q;       // sampled pattern
  addr_t     addr_q;      // address on offer
  addr_t     row_q;       // start of current row
  len_t      inner_cnt_q; // beat index in the row
  len_t      outer_cnt_q; // row index
  logic      run_q;       // for rise detection
  logic      active_q;
  logic      done_q;
  logic      start;
  logic      hs;
  logic      inner_last;
  logic      outer_last;

  assign start      = run_i & ~run_q;
  assign hs         = active_q & addr_ready_i;
  assign inner_last = inner_cnt_q == cfg_q.inner_len - len_t'(1);
  assign outer_last = outer_cnt_q == cfg_q.outer_cnt - len_t'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q       <= 1'b0;
      active_q    <= 1'b0;
      done_q      <= 1'b0;
      inner_cnt_q <= '0;
      outer_cnt_q <= '0;
    end else if (clear_i) begin
      run_q       <= 1'b0;
      active_q    <= 1'b0;
      done_q      <= 1'b0;
      inner_cnt_q <= '0;
      outer_cnt_q <= '0;
    end else begin
      run_q <= run_i;
      if (start) begin
        active_q    <= 1'b1; // first address next cycle
        inner_cnt_q <= '0;
        outer_cnt_q <= '0;
      end else if (hs) begin
        if (inner_last) begin
          inner_cnt_q <= '0;
          outer_cnt_q <= outer_cnt_q + len_t'(1);
          if (outer_last) begin
            active_q <= 1'b0;
            done_q   <= 1'b1; // held until cleared by controller
          end
        end else begin
          inner_cnt_q <= inner_cnt_q + len_t'(1);
        end
      end
    end
  end

  // address path
  always_ff @(posedge clk_i) begin
    if (start) begin
      cfg_q  <= cfg_i;
      addr_q <= cfg_i.base;
      row_q  <= cfg_i.base;
    end else if (hs) begin
      if (inner_last) begin
        row_q  <= row_q + addr_t'(cfg_q.outer_stride); // wraps like two's complement
        addr_q <= row_q + addr_t'(cfg_q.outer_stride);
      end else begin
        addr_q <= addr_q + addr_t'(cfg_q.inner_stride);
      end
    end
  end

  assign addr_o       = addr_q;
  assign addr_valid_o = active_q;
  assign done_o       = done_q;

endmodule

// ==== verilog/src_cfg_pkg.sv ====
// streamer setup types; lengths are nonzero, strides are two's complement bytes
package src_cfg_pkg;

  localparam int unsigned ADDR_FIFO_DEPTH = 2; // request stage buffer
  localparam int unsigned OFS_DEPTH       = 8; // >= loads granted but unanswered

  typedef logic        [31:0] addr_t;   // byte address
  typedef logic        [15:0] len_t;    // beats per row or row count
  typedef logic signed [31:0] stride_t; // byte step, may go backwards

  // one transfer request from the controlling host
  typedef struct packed {
    logic    req_start;    // pulse while ready_start is high
    addr_t   base;         // first byte address
    len_t    inner_len;    // beats per row
    stride_t inner_stride; // step between beats of a row
    len_t    outer_cnt;    // number of rows
    stride_t outer_stride; // step between row starts
  } src_ctrl_t;

  typedef struct packed {
    logic ready_start; // idle, accepts a new start
    logic done;        // single cycle end of transfer
  } src_flags_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WORKING, // generator still walking
    ST_DRAIN    // waiting for the last beats
  } src_state_e;

endpackage

// ==== verilog/src_ctrl.sv ====
// transfer length is latched at start; done fires once the last beat has left
`timescale 1ns/1ps

module src_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    req_start_i,
  input  src_cfg_pkg::len_t       inner_len_i,
  input  src_cfg_pkg::len_t       outer_cnt_i,
  input  logic                    gen_done_i,
  input  logic                    fifo_empty_i,
  input  logic                    beat_fire_i,
  output logic                    run_o,
  output logic                    gen_clear_o,
  output src_cfg_pkg::src_flags_t flags_o
);
  import src_cfg_pkg::*;

  typedef logic [2*$bits(len_t)-1:0] beat_cnt_t;

  src_state_e state_q;
  src_state_e state_d;
  beat_cnt_t  total_q;  // beats expected
  beat_cnt_t  beat_cnt_q;
  logic       done;

  always_comb begin
    state_d = state_q;
    done    = 1'b0;
    unique case (state_q)
      ST_IDLE:    if (req_start_i) state_d = ST_WORKING;
      ST_WORKING: if (gen_done_i) state_d = ST_DRAIN; // all addresses handed over
      ST_DRAIN: begin
        if (fifo_empty_i && beat_cnt_q == total_q) begin
          done    = 1'b1;
          state_d = ST_IDLE;
        end
      end
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      beat_cnt_q <= '0;
    end else if (clear_i) begin
      state_q    <= ST_IDLE;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (done)             beat_cnt_q <= '0;
      else if (beat_fire_i) beat_cnt_q <= beat_cnt_q + beat_cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_start_i) begin
      total_q <= inner_len_i * outer_cnt_i; // full width product
    end
  end

  assign run_o               = state_q != ST_IDLE;
  assign gen_clear_o         = clear_i | done; // rearm generator
  assign flags_o.ready_start = state_q == ST_IDLE;
  assign flags_o.done        = done;

endmodule

// ==== verilog/src_realign.sv ====
// responses must come in grant order; offset FIFO overflow is not checked
`timescale 1ns/1ps

module src_realign (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  mem_if_pkg::ofs_t         ofs_i,
  input  logic                     ofs_valid_i,
  input  mem_if_pkg::mem_rsp_t     mem_rsp_i,
  output logic                     mem_r_ready_o,
  output mem_if_pkg::stream_beat_t out_o,
  input  logic                     out_ready_i,
  output logic                     beat_fire_o
);
  import src_cfg_pkg::*;
  import mem_if_pkg::*;

  typedef logic [$clog2(OFS_DEPTH)-1:0] ofs_ptr_t;

  ofs_t         ofs_mem_q [OFS_DEPTH]; // offsets of granted loads
  ofs_ptr_t     wr_ptr_q;
  ofs_ptr_t     rd_ptr_q;
  ofs_t         ofs_head;
  stream_word_t shifted;
  stream_word_t hold_data_q;
  logic         hold_valid_q;
  logic         rsp_take;
  logic         out_valid;

  function automatic ofs_ptr_t ptr_inc(ofs_ptr_t p);
    return (p == ofs_ptr_t'(OFS_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign ofs_head = ofs_mem_q[rd_ptr_q];
  assign rsp_take = mem_rsp_i.r_valid & ~hold_valid_q; // response leaves memory
  assign shifted  = mem_rsp_i.r_data[{ofs_head, 3'b000} +: STREAM_DW]; // byte shift

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (ofs_valid_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (rsp_take)    rd_ptr_q <= ptr_inc(rd_ptr_q); // pair consumed
    end
  end

  always_ff @(posedge clk_i) begin
    if (ofs_valid_i) begin
      ofs_mem_q[wr_ptr_q] <= ofs_i;
    end
  end

  // holding register for a beat the sink refused
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (hold_valid_q) begin
      hold_valid_q <= ~out_ready_i; // drains when taken
    end else begin
      hold_valid_q <= rsp_take & ~out_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_take && !out_ready_i) begin
      hold_data_q <= shifted; // store already aligned
    end
  end

  assign out_valid     = hold_valid_q | mem_rsp_i.r_valid;
  assign out_o.valid   = out_valid;
  assign out_o.data    = hold_valid_q ? hold_data_q : shifted; // held beat first
  assign mem_r_ready_o = ~hold_valid_q; // memory keeps its response meanwhile
  assign beat_fire_o   = out_valid & out_ready_i;

endmodule

// ==== verilog/src_req_issue.sv ====
// the memory must bound outstanding loads to OFS_DEPTH; request waits only on gnt
`timescale 1ns/1ps

module src_req_issue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  src_cfg_pkg::addr_t    addr_i,
  input  logic                  addr_valid_i,
  output logic                  addr_ready_o,
  output mem_if_pkg::mem_req_t  mem_req_o,
  input  logic                  mem_gnt_i,
  output mem_if_pkg::ofs_t      ofs_o,
  output logic                  ofs_valid_o,
  output logic                  fifo_empty_o
);
  import src_cfg_pkg::*;
  import mem_if_pkg::*;

  typedef logic [$clog2(ADDR_FIFO_DEPTH+1)-1:0] cnt_t;

  addr_t fifo_q [ADDR_FIFO_DEPTH]; // entry 0 is the head
  cnt_t  cnt_q;
  cnt_t  wr_idx;
  logic  full;
  logic  empty;
  logic  req;
  logic  push;
  logic  pop;

  assign full   = cnt_q == cnt_t'(ADDR_FIFO_DEPTH);
  assign empty  = cnt_q == '0;
  assign req    = ~empty;           // head is always on the bus
  assign push   = addr_valid_i & ~full;
  assign pop    = req & mem_gnt_i;  // load accepted
  assign wr_idx = cnt_q - cnt_t'(pop); // slot after the shift

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

  // shift register storage
  always_ff @(posedge clk_i) begin
    if (pop) begin
      for (int i = 0; i < ADDR_FIFO_DEPTH - 1; i++) begin
        fifo_q[i] <= fifo_q[i+1];
      end
    end
    for (int i = 0; i < ADDR_FIFO_DEPTH; i++) begin
      if (push && wr_idx == cnt_t'(i)) begin
        fifo_q[i] <= addr_i; // overrides the shift
      end
    end
  end

  assign addr_ready_o   = ~full;
  assign mem_req_o.req  = req;
  assign mem_req_o.addr = {fifo_q[0][$bits(addr_t)-1:2], 2'b00}; // word aligned
  assign ofs_o          = fifo_q[0][1:0];
  assign ofs_valid_o    = pop; // one offset per granted load
  assign fifo_empty_o   = empty;

endmodule

// ==== verilog/src_streamer.sv ====
// source streamer top; memory answers in order and holds r_valid until r_ready
`timescale 1ns/1ps

module src_streamer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  src_cfg_pkg::src_ctrl_t   ctrl_i,
  output src_cfg_pkg::src_flags_t  flags_o,
  output mem_if_pkg::mem_req_t     mem_req_o,
  input  logic                     mem_gnt_i,
  input  mem_if_pkg::mem_rsp_t     mem_rsp_i,
  output logic                     mem_r_ready_o,
  output mem_if_pkg::stream_beat_t out_o,
  input  logic                     out_ready_i
);
  import src_cfg_pkg::*;
  import mem_if_pkg::*;

  addr_t addr;        // generator to request stage
  logic  addr_valid;
  logic  addr_ready;
  logic  gen_done;
  logic  run;
  logic  gen_clear;
  ofs_t  ofs;         // request stage to realigner
  logic  ofs_valid;
  logic  fifo_empty;
  logic  beat_fire;

  src_addrgen addrgen_inst (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( gen_clear  ),
    .run_i        ( run        ),
    .cfg_i        ( ctrl_i     ),
    .addr_o       ( addr       ),
    .addr_valid_o ( addr_valid ),
    .addr_ready_i ( addr_ready ),
    .done_o       ( gen_done   )
  );

  src_req_issue req_issue_inst (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .addr_i       ( addr       ),
    .addr_valid_i ( addr_valid ),
    .addr_ready_o ( addr_ready ),
    .mem_req_o    ( mem_req_o  ),
    .mem_gnt_i    ( mem_gnt_i  ),
    .ofs_o        ( ofs        ),
    .ofs_valid_o  ( ofs_valid  ),
    .fifo_empty_o ( fifo_empty )
  );

  src_realign realign_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .ofs_i         ( ofs           ),
    .ofs_valid_i   ( ofs_valid     ),
    .mem_rsp_i     ( mem_rsp_i     ),
    .mem_r_ready_o ( mem_r_ready_o ),
    .out_o         ( out_o         ),
    .out_ready_i   ( out_ready_i   ),
    .beat_fire_o   ( beat_fire     )
  );

  src_ctrl ctrl_inst (
    .clk_i        ( clk_i            ),
    .rst_ni       ( rst_ni           ),
    .clear_i      ( clear_i          ),
    .req_start_i  ( ctrl_i.req_start ),
    .inner_len_i  ( ctrl_i.inner_len ),
    .outer_cnt_i  ( ctrl_i.outer_cnt ),
    .gen_done_i   ( gen_done         ),
    .fifo_empty_i ( fifo_empty       ),
    .beat_fire_i  ( beat_fire        ),
    .run_o        ( run              ),
    .gen_clear_o  ( gen_clear        ),
    .flags_o      ( flags_o          )
  );

endmodule
